// File: Makefile
VERILATOR  ?= verilator
TOP        := fetch_tb
FILELIST   := compile.f
OBJ_DIR    := obj_dir
VFLAGS     := --binary --timing -j 0
LINT_FLAGS := --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "STATUS: PASS"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// File: compile.f
+incdir+include
verilog/fetch_pkg.sv
verilog/imem_wait_timer.sv
verilog/inst_sram.sv
verilog/pc_unit.sv
verilog/fetch_ctrl.sv
verilog/fetch_unit.sv
verif/tb_clkgen.sv
verif/fetch_tb.sv

// File: include/fetch_defines.svh
// Fetch stage constants for widths, addresses, SRAM geometry and halt encoding
`ifndef FETCH_DEFINES_SVH
`define FETCH_DEFINES_SVH

// PC and jump target width
`define FETCH_DATA_WIDTH 32

// First fetch address after reset
`define FETCH_RESET_PC 32'h0000_0000

// Sequential increment, one 32-bit word
`define FETCH_PC_STEP 32'd4

// Trap handler entry
`define FETCH_TRAP_VEC 32'h0000_0100

// Instruction SRAM geometry
`define IMEM_DEPTH_WORDS 256

// Wait states between read request and read data
`define IMEM_WAIT 2

// ebreak, stops the fetch stage
`define INST_EBREAK 32'h0010_0073

`endif

// File: verif/fetch_tb.sv
// Fetch stage testbench, random redirects checked against a PC and memory model
`timescale 1ns/1ps
`default_nettype none

`include "fetch_defines.svh"

module fetch_tb;

  import fetch_pkg::*;

  localparam int         NUM_TXN       = 300;
  localparam int         VALID_TIMEOUT = 50;
  localparam int         HALT_WINDOW   = 100;
  localparam logic [7:0] TRAP_IDX      = 8'(`FETCH_TRAP_VEC >> 2);

  logic       clk;
  logic       por_rst;
  logic       rst;
  logic       preload_busy;
  redirect_t  redirect;
  logic       pc_wen;
  logic       idu_ready;
  imem_load_t imem_load;
  fetch_out_t fetch_out;
  logic       inst_valid;
  logic       halted;

  // Reference model state
  logic [31:0] model_mem [`IMEM_DEPTH_WORDS];
  logic [31:0] pc_model;
  logic [31:0] rng_state;
  logic [7:0]  ebreak_idx;
  int          mismatch_count;
  int          fail_count;
  bit          abort;
  bit          stage_halted;
  int          txn;

  tb_clkgen i_clkgen (
    .clk(clk),
    .rst(por_rst)
  );

  // DUT reset also covers the SRAM preload
  assign rst = por_rst || preload_busy;

  fetch_unit i_fetch_unit (
    .clk       (clk),
    .rst       (rst),
    .redirect  (redirect),
    .pc_wen    (pc_wen),
    .idu_ready (idu_ready),
    .imem_load (imem_load),
    .fetch_out (fetch_out),
    .inst_valid(inst_valid),
    .halted    (halted)
  );

  function automatic logic [31:0] next_rand();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return rng_state;
  endfunction

  function automatic int rand_below(input int n);
    logic [31:0] r;
    r = next_rand();
    return int'(r[31:16]) % n;
  endfunction

  // Word-aligned address inside the SRAM
  function automatic logic [31:0] word_target();
    logic [31:0] r;
    r = next_rand();
    return {22'd0, r[23:16], 2'b00};
  endfunction

  function automatic redirect_t random_redirect();
    redirect_t rd;
    int        pick;
    pick           = rand_below(10);
    rd.jalr_target = word_target();
    rd.br_target   = word_target();
    rd.jal_target  = word_target();
    case (pick)
      0, 1, 2, 3: rd.sel = PC_SEQ;
      4:          rd.sel = PC_JALR;
      5:          rd.sel = PC_BRANCH;
      6:          rd.sel = PC_JAL;
      7:          rd.sel = PC_TRAP;
      // Undefined encodings 5 to 7
      default:    rd.sel = pc_sel_e'(3'd5 + 3'(rand_below(3)));
    endcase
    return rd;
  endfunction

  // Next PC as writeback expects it
  function automatic logic [31:0] predict_pc(input logic [31:0] cur, input redirect_t rd);
    case (rd.sel)
      PC_SEQ:    return cur + `FETCH_PC_STEP;
      PC_JALR:   return rd.jalr_target;
      PC_BRANCH: return rd.br_target;
      PC_JAL:    return rd.jal_target;
      default:   return `FETCH_TRAP_VEC;
    endcase
  endfunction

  task automatic check_fetch(input fetch_out_t got, input fetch_out_t exp);
    if (got !== exp) begin
      mismatch_count++;
      $display("mismatch at %0t: fetch_out got pc=%h inst=%h, expected pc=%h inst=%h",
               $time, got.pc, got.inst, exp.pc, exp.inst);
    end
  endtask

  task automatic check_halt(input bit got, input bit exp);
    if (got != exp) begin
      mismatch_count++;
      $display("mismatch at %0t: halted got %0b, expected %0b", $time, got, exp);
    end
  endtask

  task automatic check_valid(input bit got, input bit exp);
    if (got != exp) begin
      mismatch_count++;
      $display("mismatch at %0t: inst_valid got %0b, expected %0b", $time, got, exp);
    end
  endtask

  task automatic build_image();
    int          i;
    logic [31:0] w;
    for (i = 0; i < `IMEM_DEPTH_WORDS; i++) begin
      w = next_rand();
      // Keep ebreak out of the random fill
      if (w == `INST_EBREAK) begin
        w = w ^ 32'h1;
      end
      model_mem[i] = w;
    end
    // Never word 0 and never the trap slot
    ebreak_idx = 8'(1 + rand_below(255));
    if (ebreak_idx == TRAP_IDX) begin
      ebreak_idx = TRAP_IDX + 8'd1;
    end
    model_mem[ebreak_idx] = `INST_EBREAK;
  endtask

  task automatic preload_sram();
    int i;
    for (i = 0; i < `IMEM_DEPTH_WORDS; i++) begin
      @(negedge clk);
      imem_load.en   = 1'b1;
      imem_load.addr = 8'(i);
      imem_load.data = model_mem[i];
    end
    @(negedge clk);
    imem_load = '0;
  endtask

  task automatic wait_for_valid(input int limit, output bit seen);
    int n;
    seen = 1'b0;
    n    = 0;
    while (!seen && n < limit) begin
      @(negedge clk);
      seen = inst_valid;
      n++;
    end
  endtask

  task automatic run_fetch(output bit is_halt);
    fetch_out_t exp;
    bit         seen;
    int         hold_cycles;
    int         decoy_at;
    int         i;
    exp.pc   = pc_model;
    exp.inst = model_mem[pc_model[9:2]];
    is_halt  = (exp.inst == `INST_EBREAK);
    wait_for_valid(VALID_TIMEOUT, seen);
    if (!seen) begin
      fail_count++;
      abort = 1'b1;
      $display("error at %0t: no inst_valid within %0d cycles for pc %h",
               $time, VALID_TIMEOUT, exp.pc);
      return;
    end
    check_fetch(fetch_out, exp);
    // Back-pressure, sometimes with a stray pc_wen
    hold_cycles = rand_below(6);
    decoy_at    = (hold_cycles > 0) ? rand_below(hold_cycles) : -1;
    for (i = 0; i < hold_cycles; i++) begin
      if (i == decoy_at) begin
        redirect = random_redirect();
        pc_wen   = 1'b1;
      end
      @(negedge clk);
      pc_wen = 1'b0;
      check_valid(inst_valid, 1'b1);
      check_fetch(fetch_out, exp);
    end
    idu_ready = 1'b1;
    @(negedge clk);
    idu_ready = 1'b0;
    check_valid(inst_valid, 1'b0);
    check_halt(halted, is_halt);
  endtask

  task automatic advance_pc(input bit final_hop);
    redirect_t   rd;
    logic [31:0] next_pc;
    int          gap;
    int          i;
    gap = rand_below(4);
    for (i = 0; i < gap; i++) begin
      @(negedge clk);
      check_valid(inst_valid, 1'b0);
    end
    rd      = random_redirect();
    next_pc = predict_pc(pc_model, rd);
    if (final_hop) begin
      rd.sel        = PC_JAL;
      rd.jal_target = {22'd0, ebreak_idx, 2'b00};
      next_pc       = predict_pc(pc_model, rd);
    end else if (next_pc[9:2] == ebreak_idx) begin
      // Steer clear of ebreak until the last hop
      rd.sel  = PC_TRAP;
      next_pc = predict_pc(pc_model, rd);
    end
    redirect = rd;
    pc_wen   = 1'b1;
    @(negedge clk);
    pc_wen   = 1'b0;
    pc_model = next_pc;
  endtask

  task automatic watch_halt();
    int n;
    bit valid_seen;
    n          = 0;
    valid_seen = 1'b0;
    while (n < HALT_WINDOW && !valid_seen) begin
      // Writeback strobes must not restart a halted stage
      if (n % 25 == 3) begin
        redirect = random_redirect();
        pc_wen   = 1'b1;
      end
      @(negedge clk);
      pc_wen     = 1'b0;
      valid_seen = inst_valid;
      check_halt(halted, 1'b1);
      n++;
    end
    if (valid_seen) begin
      fail_count++;
      $display("error at %0t: inst_valid rose after the stage halted", $time);
    end
  endtask

  initial begin
    redirect       = '0;
    pc_wen         = 1'b0;
    idu_ready      = 1'b0;
    imem_load      = '0;
    preload_busy   = 1'b1;
    rng_state      = 32'd93;
    pc_model       = `FETCH_RESET_PC;
    mismatch_count = 0;
    fail_count     = 0;
    abort          = 1'b0;
    stage_halted   = 1'b0;

    build_image();
    preload_sram();
    preload_busy = 1'b0;

    @(negedge clk);
    check_valid(inst_valid, 1'b0);
    check_halt(halted, 1'b0);

    txn = 0;
    while (!abort && !stage_halted && txn <= NUM_TXN) begin
      run_fetch(stage_halted);
      if (!abort && !stage_halted) begin
        advance_pc(txn == NUM_TXN - 1);
      end
      txn++;
    end

    if (stage_halted && !abort) begin
      watch_halt();
    end else if (!abort) begin
      fail_count++;
      $display("error: the stage never fetched the ebreak word");
    end

    $display("errors: %0d mismatches, %0d other failures", mismatch_count, fail_count);
    if (mismatch_count == 0 && fail_count == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: verif/tb_clkgen.sv
// Testbench clock and power-on reset source
`timescale 1ns/1ps
`default_nettype none

module tb_clkgen #(
  parameter real PERIOD_NS    = 8.0,
  parameter int  RESET_CYCLES = 10
) (
  output logic clk,
  output logic rst
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2.0) clk = ~clk;
  end

  // Released on a falling edge, away from the sampling edge
  initial begin
    rst = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
  end

endmodule

`default_nettype wire

// File: verilog/fetch_ctrl.sv
// Fetch controller FSM, one outstanding SRAM read with a held instruction buffer
`timescale 1ns/1ps
`default_nettype none

`include "fetch_defines.svh"

module fetch_ctrl (
  input  wire        clk,
  input  wire        rst,
  input  wire        pc_wen,
  input  wire        rd_valid,
  input  wire [31:0] rdata,
  input  wire        idu_ready,
  output logic       rd_req,
  output logic       pc_advance,
  output logic [31:0] inst,
  output logic       inst_valid,
  output logic       halted
);

  import fetch_pkg::*;

  fetch_state_e state;
  logic [31:0]  inst_buf;
  logic         accept;

  // Handshake completes only once valid is already on the wire
  assign accept = (state == S_DONE) && inst_valid && idu_ready;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state      <= S_REQ;
      rd_req     <= 1'b0;
      inst_valid <= 1'b0;
    end else begin
      case (state)
        S_REQ: begin
          rd_req     <= 1'b1;
          inst_valid <= 1'b0;
          state      <= S_WAIT;
        end

        S_WAIT: begin
          rd_req <= 1'b0;
          if (rd_valid) begin
            state <= S_DONE;
          end
        end

        S_DONE: begin
          if (accept) begin
            inst_valid <= 1'b0;
            // ebreak parks the stage until reset
            if (inst_buf == `INST_EBREAK) begin
              state <= S_HALT;
            end else begin
              state <= S_IDLE;
            end
          end else begin
            inst_valid <= 1'b1;
          end
        end

        S_IDLE: begin
          if (pc_wen) begin
            state <= S_REQ;
          end
        end

        S_HALT: begin
          rd_req     <= 1'b0;
          inst_valid <= 1'b0;
        end

        default: begin
          state      <= S_IDLE;
          rd_req     <= 1'b0;
          inst_valid <= 1'b0;
        end
      endcase
    end
  end

  // Capture read data for the decode stage
  always_ff @(posedge clk) begin
    if ((state == S_WAIT) && rd_valid) begin
      inst_buf <= rdata;
    end
  end

  // Writeback strobe only counts while idle
  assign pc_advance = (state == S_IDLE) && pc_wen;
  assign inst       = inst_buf;
  assign halted     = (state == S_HALT);

endmodule

`default_nettype wire

// File: verilog/fetch_pkg.sv
// Fetch stage types shared by the RTL and the testbench
`default_nettype none

`include "fetch_defines.svh"

package fetch_pkg;

  // Next-PC source select
  typedef enum logic [2:0] {
    PC_SEQ    = 3'd0,
    PC_JALR   = 3'd1,
    PC_BRANCH = 3'd2,
    PC_JAL    = 3'd3,
    PC_TRAP   = 3'd4
  } pc_sel_e;

  // Fetch controller states
  typedef enum logic [2:0] {
    S_REQ  = 3'd0,
    S_WAIT = 3'd1,
    S_DONE = 3'd2,
    S_IDLE = 3'd3,
    S_HALT = 3'd4
  } fetch_state_e;

  // Redirect request from the later stages
  typedef struct packed {
    pc_sel_e                      sel;
    logic [`FETCH_DATA_WIDTH-1:0] jalr_target;
    logic [`FETCH_DATA_WIDTH-1:0] br_target;
    logic [`FETCH_DATA_WIDTH-1:0] jal_target;
  } redirect_t;

  // Fetched word and the address it came from
  typedef struct packed {
    logic [`FETCH_DATA_WIDTH-1:0] pc;
    logic [31:0]                  inst;
  } fetch_out_t;

  // One-word SRAM preload
  typedef struct packed {
    logic        en;
    logic [7:0]  addr;
    logic [31:0] data;
  } imem_load_t;

endpackage

`default_nettype wire

// File: verilog/fetch_unit.sv
// Instruction fetch stage top, controller plus PC unit plus timed instruction SRAM
`timescale 1ns/1ps
`default_nettype none

`include "fetch_defines.svh"

module fetch_unit (
  input  wire                    clk,
  input  wire                    rst,
  input  fetch_pkg::redirect_t   redirect,
  input  wire                    pc_wen,
  input  wire                    idu_ready,
  input  fetch_pkg::imem_load_t  imem_load,
  output fetch_pkg::fetch_out_t  fetch_out,
  output logic                   inst_valid,
  output logic                   halted
);

  logic [`FETCH_DATA_WIDTH-1:0] pc;
  logic                         rd_req;
  logic                         pc_advance;
  logic                         tmr_done;
  logic                         rd_valid;
  logic [31:0]                  rdata;
  logic [31:0]                  inst;

  fetch_ctrl i_fetch_ctrl (
    .clk       (clk),
    .rst       (rst),
    .pc_wen    (pc_wen),
    .rd_valid  (rd_valid),
    .rdata     (rdata),
    .idu_ready (idu_ready),
    .rd_req    (rd_req),
    .pc_advance(pc_advance),
    .inst      (inst),
    .inst_valid(inst_valid),
    .halted    (halted)
  );

  pc_unit i_pc_unit (
    .clk       (clk),
    .rst       (rst),
    .redirect  (redirect),
    .pc_advance(pc_advance),
    .pc        (pc)
  );

  imem_wait_timer i_wait_timer (
    .clk  (clk),
    .rst  (rst),
    .start(rd_req),
    .busy (),
    .done (tmr_done)
  );

  inst_sram i_inst_sram (
    .clk     (clk),
    .rst     (rst),
    .load    (imem_load),
    .rd_req  (rd_req),
    .addr    (pc),
    .rd_done (tmr_done),
    .rd_valid(rd_valid),
    .rdata   (rdata)
  );

  assign fetch_out.pc   = pc;
  assign fetch_out.inst = inst;

endmodule

`default_nettype wire

// File: verilog/imem_wait_timer.sv
// Wait-state down-counter for the instruction SRAM read path
`timescale 1ns/1ps
`default_nettype none

`include "fetch_defines.svh"

module imem_wait_timer (
  input  wire  clk,
  input  wire  rst,
  input  wire  start,
  output logic busy,
  output logic done
);

  localparam int CNT_W = $clog2(`IMEM_WAIT + 1);

  logic [CNT_W-1:0] count;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      count <= '0;
    end else if (start) begin
      count <= CNT_W'(`IMEM_WAIT);
    end else if (busy) begin
      count <= count - 1'b1;
    end
  end

  assign busy = (count != '0);

  // Last wait state, data is ready this cycle
  assign done = (count == CNT_W'(1));

endmodule

`default_nettype wire

// File: verilog/inst_sram.sv
// Instruction SRAM with a preload port and a timer-paced read response
`timescale 1ns/1ps
`default_nettype none

`include "fetch_defines.svh"

module inst_sram (
  input  wire                    clk,
  input  wire                    rst,
  input  fetch_pkg::imem_load_t  load,
  input  wire                    rd_req,
  input  wire [31:0]             addr,
  input  wire                    rd_done,
  output logic                   rd_valid,
  output logic [31:0]            rdata
);

  localparam int IDX_W = $clog2(`IMEM_DEPTH_WORDS);

  logic [31:0]      mem [`IMEM_DEPTH_WORDS];
  logic [IDX_W-1:0] idx_q;
  logic [31:0]      rdata_q;
  logic             rd_pend;

  // Preload, one word per cycle
  always_ff @(posedge clk) begin
    if (load.en) begin
      mem[load.addr] <= load.data;
    end
  end

  // Word index of the outstanding read
  always_ff @(posedge clk) begin
    if (rd_req) begin
      idx_q <= addr[9:2];
    end
  end

  // Synchronous array read, settles during the wait states
  always_ff @(posedge clk) begin
    if (rd_pend) begin
      rdata_q <= mem[idx_q];
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      rd_pend <= 1'b0;
    end else if (rd_req) begin
      rd_pend <= 1'b1;
    end else if (rd_done) begin
      rd_pend <= 1'b0;
    end
  end

  assign rd_valid = rd_pend && rd_done;
  assign rdata    = rdata_q;

endmodule

`default_nettype wire

// File: verilog/pc_unit.sv
// Program counter register with five-way next-PC selection
`timescale 1ns/1ps
`default_nettype none

`include "fetch_defines.svh"

module pc_unit (
  input  wire                            clk,
  input  wire                            rst,
  input  fetch_pkg::redirect_t           redirect,
  input  wire                            pc_advance,
  output logic [`FETCH_DATA_WIDTH-1:0]   pc
);

  import fetch_pkg::*;

  logic [`FETCH_DATA_WIDTH-1:0] pc_q;
  logic [`FETCH_DATA_WIDTH-1:0] pc_next;

  always_comb begin
    case (redirect.sel)
      PC_SEQ:    pc_next = pc_q + `FETCH_PC_STEP;
      PC_JALR:   pc_next = redirect.jalr_target;
      PC_BRANCH: pc_next = redirect.br_target;
      PC_JAL:    pc_next = redirect.jal_target;
      PC_TRAP:   pc_next = `FETCH_TRAP_VEC;
      // Unknown selects trap as well
      default:   pc_next = `FETCH_TRAP_VEC;
    endcase
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      pc_q <= `FETCH_RESET_PC;
    end else if (pc_advance) begin
      pc_q <= pc_next;
    end
  end

  assign pc = pc_q;

endmodule

`default_nettype wire
